//--- verilog/vread_pkg.sv
package vread_pkg;

   // bus and buffer word width
   localparam int DATA_W = 32;

   // byte address on the external bus
   localparam int BUS_ADDR_W = 16;

   // buffer word address, top bit selects the half
   localparam int ADDR_W = 7;
   localparam int HALF_W = 6;

   // burst length and word count
   localparam int LEN_W = 7;

   // address generator fields
   localparam int PERIOD_W = 6;
   localparam int DELAY_W  = 6;

   // bus address step per beat
   localparam int WORD_BYTES = 4;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACTIVE,
      ST_DRAIN
   } ctrl_state_t;

   typedef enum logic [1:0] {
      BR_IDLE,
      BR_ADDR,
      BR_DATA,
      BR_DONE
   } burst_state_t;

endpackage

//--- verilog/vread_ctrl.sv
`timescale 1ns/1ps

module vread_ctrl
   import vread_pkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic run_i,
   input  logic fetch_done_i,
   input  logic gen_done_i,
   output logic start_o,
   output logic fill_half_o,
   output logic done_o
);

   ctrl_state_t state;
   logic        fetch_seen;
   logic        gen_seen;
   logic        fetch_seen_nxt;
   logic        gen_seen_nxt;

   // sticky view including this cycle's pulses
   assign fetch_seen_nxt = fetch_seen | fetch_done_i;
   assign gen_seen_nxt   = gen_seen | gen_done_i;

   // idle means the last run has fully finished
   assign done_o = (state == ST_IDLE);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= ST_IDLE;
         start_o     <= 1'b0;
         fill_half_o <= 1'b0;
         fetch_seen  <= 1'b0;
         gen_seen    <= 1'b0;
      end else begin
         start_o <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (run_i) begin
                  // swap halves together with the start pulse
                  state       <= ST_ACTIVE;
                  start_o     <= 1'b1;
                  fill_half_o <= ~fill_half_o;
                  fetch_seen  <= 1'b0;
                  gen_seen    <= 1'b0;
               end
            end
            ST_ACTIVE, ST_DRAIN: begin
               fetch_seen <= fetch_seen_nxt;
               gen_seen   <= gen_seen_nxt;
               if (fetch_seen_nxt && gen_seen_nxt) begin
                  state <= ST_IDLE;
               end else if (fetch_seen_nxt || gen_seen_nxt) begin
                  // one side finished, wait for the other
                  state <= ST_DRAIN;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

//--- verilog/addr_gen.sv
`timescale 1ns/1ps

module addr_gen
   import vread_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic                start_i,
   input  logic [DELAY_W-1:0]  delay_i,
   input  logic [HALF_W-1:0]   start_addr_i,
   input  logic [HALF_W-1:0]   incr_i,
   input  logic [HALF_W-1:0]   shift_i,
   input  logic [PERIOD_W-1:0] period_i,
   input  logic [PERIOD_W-1:0] duty_i,
   input  logic [HALF_W-1:0]   iter_i,
   output logic                rd_en_o,
   output logic [HALF_W-1:0]   rd_addr_o,
   output logic                done_o
);

   logic                busy;
   logic                finish;
   logic [DELAY_W-1:0]  delay_cnt;
   logic [PERIOD_W-1:0] pos;
   logic [HALF_W-1:0]   iter_cnt;
   logic [HALF_W-1:0]   addr;
   logic [HALF_W-1:0]   base;
   logic                empty;
   logic                issue;
   logic                last_pos;
   logic                last_slot;

   // zero period or zero iterations means nothing to stream
   assign empty     = (period_i == '0) || (iter_i == '0);
   assign issue     = busy && (delay_cnt == '0) && !empty;
   assign last_pos  = (pos == period_i - 1'b1);
   assign last_slot = last_pos && (iter_cnt == iter_i - 1'b1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy      <= 1'b0;
         finish    <= 1'b0;
         done_o    <= 1'b0;
         rd_en_o   <= 1'b0;
         delay_cnt <= '0;
         pos       <= '0;
         iter_cnt  <= '0;
         addr      <= '0;
         base      <= '0;
      end else begin
         done_o  <= finish;
         finish  <= 1'b0;
         rd_en_o <= 1'b0;
         if (start_i) begin
            busy      <= 1'b1;
            delay_cnt <= delay_i;
            pos       <= '0;
            iter_cnt  <= '0;
            addr      <= start_addr_i;
            base      <= start_addr_i;
         end else if (busy) begin
            if (delay_cnt != '0) begin
               delay_cnt <= delay_cnt - 1'b1;
            end else if (empty) begin
               busy   <= 1'b0;
               finish <= 1'b1;
            end else begin
               // slots past duty are counted but not read
               rd_en_o <= (pos < duty_i);
               if (last_pos) begin
                  pos      <= '0;
                  iter_cnt <= iter_cnt + 1'b1;
                  base     <= base + shift_i;
                  addr     <= base + shift_i;
               end else begin
                  pos  <= pos + 1'b1;
                  addr <= addr + incr_i;
               end
               if (last_slot) begin
                  busy   <= 1'b0;
                  finish <= 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         rd_addr_o <= addr;
      end
   end

endmodule

//--- verilog/burst_reader.sv
`timescale 1ns/1ps

module burst_reader
   import vread_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start_i,
   input  logic [BUS_ADDR_W-1:0] ext_addr_i,
   input  logic [LEN_W-1:0]      count_i,
   input  logic [LEN_W-1:0]      burst_len_i,
   output logic                  bus_avalid_o,
   input  logic                  bus_aready_i,
   output logic [BUS_ADDR_W-1:0] bus_addr_o,
   output logic [LEN_W-1:0]      bus_len_o,
   input  logic                  bus_rvalid_i,
   input  logic [DATA_W-1:0]     bus_rdata_i,
   input  logic                  bus_rlast_i,
   output logic                  wr_en_o,
   output logic [HALF_W-1:0]     wr_addr_o,
   output logic [DATA_W-1:0]     wr_data_o,
   output logic                  fetch_done_o
);

   burst_state_t          state;
   logic [LEN_W-1:0]      remaining;
   logic [LEN_W-1:0]      cur_len;
   logic [BUS_ADDR_W-1:0] addr_q;
   logic [HALF_W-1:0]     wr_idx;
   logic                  beat;

   // next burst is the smaller of words left and the burst limit
   assign cur_len = (remaining < burst_len_i) ? remaining : burst_len_i;

   assign bus_avalid_o = (state == BR_ADDR);
   assign bus_addr_o   = addr_q;
   assign bus_len_o    = cur_len - 1'b1;

   // each returned beat goes straight into the buffer
   assign beat      = (state == BR_DATA) && bus_rvalid_i;
   assign wr_en_o   = beat;
   assign wr_addr_o = wr_idx;
   assign wr_data_o = bus_rdata_i;

   assign fetch_done_o = (state == BR_DONE);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= BR_IDLE;
         remaining <= '0;
         addr_q    <= '0;
         wr_idx    <= '0;
      end else begin
         case (state)
            BR_IDLE: begin
               if (start_i) begin
                  remaining <= count_i;
                  addr_q    <= ext_addr_i;
                  wr_idx    <= '0;
                  state     <= (count_i == '0) ? BR_DONE : BR_ADDR;
               end
            end
            BR_ADDR: begin
               // address and length hold until accepted
               if (bus_aready_i) begin
                  state <= BR_DATA;
               end
            end
            BR_DATA: begin
               if (bus_rvalid_i) begin
                  remaining <= remaining - 1'b1;
                  addr_q    <= addr_q + BUS_ADDR_W'(WORD_BYTES);
                  wr_idx    <= wr_idx + 1'b1;
                  if (bus_rlast_i) begin
                     state <= (remaining == LEN_W'(1)) ? BR_DONE : BR_ADDR;
                  end
               end
            end
            BR_DONE: state <= BR_IDLE;
            default: state <= BR_IDLE;
         endcase
      end
   end

endmodule

//--- verilog/pingpong_buffer.sv
`timescale 1ns/1ps

module pingpong_buffer
   import vread_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              fill_half_i,
   input  logic              wr_en_i,
   input  logic [HALF_W-1:0] wr_addr_i,
   input  logic [DATA_W-1:0] wr_data_i,
   input  logic              rd_en_i,
   input  logic [HALF_W-1:0] rd_addr_i,
   output logic              rd_valid_o,
   output logic [DATA_W-1:0] rd_data_o
);

   logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];
   logic [ADDR_W-1:0] wr_idx;
   logic [ADDR_W-1:0] rd_idx;

   // fetch fills one half, the stream reads the other
   assign wr_idx = {fill_half_i, wr_addr_i};
   assign rd_idx = {~fill_half_i, rd_addr_i};

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_idx] <= wr_data_i;
      end
      if (rd_en_i) begin
         rd_data_o <= mem[rd_idx];
      end
   end

   // one cycle read latency
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= rd_en_i;
      end
   end

endmodule

//--- verilog/vread_top.sv
`timescale 1ns/1ps

module vread_top
   import vread_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   output logic                  done_o,
   input  logic [BUS_ADDR_W-1:0] ext_addr_i,
   input  logic [LEN_W-1:0]      count_i,
   input  logic [LEN_W-1:0]      burst_len_i,
   input  logic [HALF_W-1:0]     start_i,
   input  logic [HALF_W-1:0]     incr_i,
   input  logic [HALF_W-1:0]     shift_i,
   input  logic [PERIOD_W-1:0]   period_i,
   input  logic [PERIOD_W-1:0]   duty_i,
   input  logic [HALF_W-1:0]     iter_i,
   input  logic [DELAY_W-1:0]    delay_i,
   output logic                  bus_avalid_o,
   input  logic                  bus_aready_i,
   output logic [BUS_ADDR_W-1:0] bus_addr_o,
   output logic [LEN_W-1:0]      bus_len_o,
   input  logic                  bus_rvalid_i,
   input  logic [DATA_W-1:0]     bus_rdata_i,
   input  logic                  bus_rlast_i,
   output logic                  out_valid_o,
   output logic [DATA_W-1:0]     out_data_o
);

   logic              start;
   logic              fill_half;
   logic              fetch_done;
   logic              gen_done;
   logic              wr_en;
   logic [HALF_W-1:0] wr_addr;
   logic [DATA_W-1:0] wr_data;
   logic              rd_en;
   logic [HALF_W-1:0] rd_addr;

   vread_ctrl u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run_i),
      .fetch_done_i (fetch_done),
      .gen_done_i   (gen_done),
      .start_o      (start),
      .fill_half_o  (fill_half),
      .done_o       (done_o)
   );

   burst_reader u_reader (
      .clk          (clk),
      .rst          (rst),
      .start_i      (start),
      .ext_addr_i   (ext_addr_i),
      .count_i      (count_i),
      .burst_len_i  (burst_len_i),
      .bus_avalid_o (bus_avalid_o),
      .bus_aready_i (bus_aready_i),
      .bus_addr_o   (bus_addr_o),
      .bus_len_o    (bus_len_o),
      .bus_rvalid_i (bus_rvalid_i),
      .bus_rdata_i  (bus_rdata_i),
      .bus_rlast_i  (bus_rlast_i),
      .wr_en_o      (wr_en),
      .wr_addr_o    (wr_addr),
      .wr_data_o    (wr_data),
      .fetch_done_o (fetch_done)
   );

   // read outputs double as the output stream
   pingpong_buffer u_buffer (
      .clk         (clk),
      .rst         (rst),
      .fill_half_i (fill_half),
      .wr_en_i     (wr_en),
      .wr_addr_i   (wr_addr),
      .wr_data_i   (wr_data),
      .rd_en_i     (rd_en),
      .rd_addr_i   (rd_addr),
      .rd_valid_o  (out_valid_o),
      .rd_data_o   (out_data_o)
   );

   addr_gen u_gen (
      .clk          (clk),
      .rst          (rst),
      .start_i      (start),
      .delay_i      (delay_i),
      .start_addr_i (start_i),
      .incr_i       (incr_i),
      .shift_i      (shift_i),
      .period_i     (period_i),
      .duty_i       (duty_i),
      .iter_i       (iter_i),
      .rd_en_o      (rd_en),
      .rd_addr_o    (rd_addr),
      .done_o       (gen_done)
   );

endmodule

//--- test/ext_mem_model.sv
`timescale 1ns/1ps

module ext_mem_model
   import vread_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  avalid_i,
   output logic                  aready_o,
   input  logic [BUS_ADDR_W-1:0] addr_i,
   input  logic [LEN_W-1:0]      len_i,
   output logic                  rvalid_o,
   output logic [DATA_W-1:0]     rdata_o,
   output logic                  rlast_o
);

   logic                  busy;
   logic [BUS_ADDR_W-1:0] cur;
   logic [7:0]            left;
   logic [31:0]           rnd;

   function automatic logic [31:0] next_rand(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // memory contents depend on every address bit
   function automatic logic [DATA_W-1:0] word_at(logic [BUS_ADDR_W-1:0] a);
      return {~a, a} ^ 32'h3c96_0f1e;
   endfunction

   // bookkeeping follows the handshakes seen at the rising edge
   always @(posedge clk or posedge rst) begin
      if (rst) begin
         busy <= 1'b0;
         cur  <= '0;
         left <= '0;
      end else begin
         if (avalid_i && aready_o) begin
            busy <= 1'b1;
            cur  <= addr_i;
            left <= {1'b0, len_i} + 8'd1;
         end
         if (rvalid_o) begin
            cur  <= cur + 16'd4;
            left <= left - 8'd1;
            if (left == 8'd1) begin
               busy <= 1'b0;
            end
         end
      end
   end

   // outputs change on the falling edge, with random gaps
   always @(negedge clk or posedge rst) begin
      if (rst) begin
         rnd      <= 32'd56;
         aready_o <= 1'b0;
         rvalid_o <= 1'b0;
         rdata_o  <= '0;
         rlast_o  <= 1'b0;
      end else begin
         rnd <= next_rand(rnd);
         if (busy) begin
            aready_o <= 1'b0;
            rvalid_o <= rnd[0] | rnd[1];
            rdata_o  <= word_at(cur);
            rlast_o  <= (left == 8'd1);
         end else begin
            aready_o <= rnd[2];
            rvalid_o <= 1'b0;
            rlast_o  <= 1'b0;
         end
      end
   end

endmodule

//--- test/tb_vread.sv
`timescale 1ns/1ps

module tb_vread
   import vread_pkg::*;
;

   localparam int NRUNS = 6;
   localparam int RESET_CYCLES = 8;

   // one column per run
   int cfg_addr   [NRUNS] = '{16'h0100, 16'h0400, 16'h0800, 16'h1000, 16'h2004, 16'h0000};
   int cfg_count  [NRUNS] = '{64, 20, 40, 33, 8, 1};
   int cfg_burst  [NRUNS] = '{16, 8, 5, 64, 3, 1};
   int cfg_start  [NRUNS] = '{0, 0, 0, 5, 30, 2};
   int cfg_incr   [NRUNS] = '{1, 1, 1, 3, 63, 2};
   int cfg_shift  [NRUNS] = '{4, 16, 8, 7, 1, 0};
   int cfg_period [NRUNS] = '{4, 4, 4, 5, 3, 2};
   int cfg_duty   [NRUNS] = '{4, 4, 2, 3, 3, 1};
   int cfg_iter   [NRUNS] = '{16, 16, 3, 4, 2, 5};
   int cfg_delay  [NRUNS] = '{3, 2, 0, 5, 1, 0};

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  run_i;
   logic                  done_o;
   logic [BUS_ADDR_W-1:0] ext_addr_i;
   logic [LEN_W-1:0]      count_i;
   logic [LEN_W-1:0]      burst_len_i;
   logic [HALF_W-1:0]     start_i;
   logic [HALF_W-1:0]     incr_i;
   logic [HALF_W-1:0]     shift_i;
   logic [PERIOD_W-1:0]   period_i;
   logic [PERIOD_W-1:0]   duty_i;
   logic [HALF_W-1:0]     iter_i;
   logic [DELAY_W-1:0]    delay_i;
   logic                  bus_avalid_o;
   logic                  bus_aready_i;
   logic [BUS_ADDR_W-1:0] bus_addr_o;
   logic [LEN_W-1:0]      bus_len_o;
   logic                  bus_rvalid_i;
   logic [DATA_W-1:0]     bus_rdata_i;
   logic                  bus_rlast_i;
   logic                  out_valid_o;
   logic [DATA_W-1:0]     out_data_o;

   int                    cycles;
   int                    limit;
   int                    out_cnt;
   int                    beat_cnt;
   bit                    checking;
   bit                    pend;
   logic [BUS_ADDR_W-1:0] held_addr;
   logic [LEN_W-1:0]      held_len;
   logic [DATA_W-1:0]     exp_q [$];
   int                    acc_len [$];
   int                    acc_addr [$];

   vread_top uut (.*);

   ext_mem_model u_mem (
      .clk      (clk),
      .rst      (rst),
      .avalid_i (bus_avalid_o),
      .aready_o (bus_aready_i),
      .addr_i   (bus_addr_o),
      .len_i    (bus_len_o),
      .rvalid_o (bus_rvalid_i),
      .rdata_o  (bus_rdata_i),
      .rlast_o  (bus_rlast_i)
   );

   always #5 clk = ~clk;

   task automatic check_value(string name, logic [31:0] exp, logic [31:0] got);
      if (got !== exp) begin
         $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   task automatic fail_run(string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   function automatic logic [31:0] mem_pattern(logic [15:0] a);
      return {~a, a} ^ 32'h3c96_0f1e;
   endfunction

   // slots per period that actually read
   function automatic int active_slots(int r);
      return (cfg_duty[r] < cfg_period[r]) ? cfg_duty[r] : cfg_period[r];
   endfunction

   // n-th word streamed in run r comes from what run r-1 fetched
   function automatic logic [31:0] ref_word(int r, int n);
      int d;
      int i;
      int p;
      int idx;
      d   = active_slots(r);
      i   = n / d;
      p   = n % d;
      idx = (cfg_start[r] + i * cfg_shift[r] + p * cfg_incr[r]) % 64;
      return mem_pattern(16'(cfg_addr[r-1] + 4 * idx));
   endfunction

   // comparator for the output stream
   always @(posedge clk) begin
      if (!rst && out_valid_o) begin
         out_cnt++;
         if (checking) begin
            if (exp_q.size() == 0) begin
               fail_run("output stream produced more words than expected");
            end else begin
               check_value("out_data_o", exp_q.pop_front(), out_data_o);
            end
         end
      end
   end

   // address phase must hold on the bus while not accepted
   always @(posedge clk) begin
      if (!rst) begin
         if (pend) begin
            check_value("bus_avalid_o", 32'd1, 32'(bus_avalid_o));
            check_value("bus_addr_o", 32'(held_addr), 32'(bus_addr_o));
            check_value("bus_len_o", 32'(held_len), 32'(bus_len_o));
         end
         if (bus_avalid_o && bus_aready_i) begin
            acc_len.push_back(int'(bus_len_o) + 1);
            acc_addr.push_back(int'(bus_addr_o));
         end
         pend      = bus_avalid_o && !bus_aready_i;
         held_addr = bus_addr_o;
         held_len  = bus_len_o;
         if (bus_rvalid_i) begin
            beat_cnt++;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= limit) begin
         $display("timeout: the run did not finish within %0d cycles", limit);
         $display("Simulation FAILED");
         $fatal(1);
      end
   end

   task automatic do_run(int r);
      int n_exp;
      int rem;
      int a;
      int bl;
      int k;
      @(negedge clk);
      ext_addr_i  = 16'(cfg_addr[r]);
      count_i     = 7'(cfg_count[r]);
      burst_len_i = 7'(cfg_burst[r]);
      start_i     = 6'(cfg_start[r]);
      incr_i      = 6'(cfg_incr[r]);
      shift_i     = 6'(cfg_shift[r]);
      period_i    = 6'(cfg_period[r]);
      duty_i      = 6'(cfg_duty[r]);
      iter_i      = 6'(cfg_iter[r]);
      delay_i     = 6'(cfg_delay[r]);
      exp_q.delete();
      acc_len.delete();
      acc_addr.delete();
      out_cnt  = 0;
      beat_cnt = 0;
      // first run streams a half nobody has filled yet
      checking = (r > 0);
      n_exp = cfg_iter[r] * active_slots(r);
      if (r > 0) begin
         for (k = 0; k < n_exp; k++) begin
            exp_q.push_back(ref_word(r, k));
         end
      end
      run_i = 1'b1;
      @(negedge clk);
      run_i = 1'b0;
      check_value("done_o", 32'd0, 32'(done_o));
      while (!done_o) begin
         @(negedge clk);
      end
      check_value("output count", 32'(n_exp), 32'(out_cnt));
      check_value("bus beat count", 32'(cfg_count[r]), 32'(beat_cnt));
      // rebuild the burst split
      rem = cfg_count[r];
      a   = cfg_addr[r];
      k   = 0;
      while (rem > 0) begin
         bl = (rem < cfg_burst[r]) ? rem : cfg_burst[r];
         if (k >= acc_len.size()) begin
            fail_run("fewer bus requests than the burst split needs");
         end
         check_value("bus_len_o", 32'(bl), 32'(acc_len[k]));
         check_value("bus_addr_o", 32'(a), 32'(acc_addr[k]));
         a   = a + WORD_BYTES * bl;
         rem = rem - bl;
         k++;
      end
      check_value("bus request count", 32'(k), 32'(acc_len.size()));
   endtask

   initial begin
      int sum;
      int r;
      rst         = 1'b1;
      run_i       = 1'b0;
      ext_addr_i  = '0;
      count_i     = '0;
      burst_len_i = '0;
      start_i     = '0;
      incr_i      = '0;
      shift_i     = '0;
      period_i    = '0;
      duty_i      = '0;
      iter_i      = '0;
      delay_i     = '0;
      checking    = 1'b0;
      pend        = 1'b0;
      cycles      = 0;
      out_cnt     = 0;
      beat_cnt    = 0;
      sum = 0;
      for (r = 0; r < NRUNS; r++) begin
         sum += cfg_count[r] + cfg_delay[r] + cfg_iter[r] * cfg_period[r];
      end
      limit = 20 * sum + RESET_CYCLES;
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_value("done_o", 32'd1, 32'(done_o));
      check_value("out_valid_o", 32'd0, 32'(out_valid_o));
      check_value("bus_avalid_o", 32'd0, 32'(bus_avalid_o));
      for (r = 0; r < NRUNS; r++) begin
         do_run(r);
      end
      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- files.f
verilog/vread_pkg.sv
verilog/vread_ctrl.sv
verilog/addr_gen.sv
verilog/burst_reader.sv
verilog/pingpong_buffer.sv
verilog/vread_top.sv
test/ext_mem_model.sv
test/tb_vread.sv

//--- run.sh
#!/bin/sh
# build and run the read unit testbench; exit status follows the simulation
verilator --binary --timing -f files.f --top-module tb_vread -o sim_vread \
   && ./obj_dir/sim_vread \
   || exit 1
